/* src.f */
+incdir+rtl
rtl/hdc_isa_pkg.sv
rtl/hdc_bus_pkg.sv
rtl/hdc_exec_if.sv
rtl/hdc_regs.sv
rtl/hdc_core.sv
rtl/hdc_bundler.sv
rtl/hdc_top.sv
tb/tb_hdc_top.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_hdc_top
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_hdc_top.sv */
`timescale 1ns/1ps
`include "hdc_cfg.svh"

module tb_hdc_top;

    // the tests need about 350 cycles
    localparam int MAX_CYCLES = 4000;
    localparam int CNT_MAX    = (1 << `HDC_CNT_W) - 1;

    logic          clk;
    logic          reset;
    logic [7:0]    paddr;
    logic          psel;
    logic          penable;
    logic          pwrite;
    logic [31:0]   pwdata;
    logic [31:0]   prdata;
    logic          pready;
    logic          pslverr;

    integer        seed;
    int            cycles = 0;
    int            pass_count;
    int            fail_count;
    int            test_fails;
    string         test_name;
    logic          bus_err;

    // reference model of the core registers and the bundle
    logic [`HDC_DIM-1:0]   m_mem [`HDC_ITEMS];
    logic [`HDC_DIM-1:0]   m_reg1;
    logic [`HDC_DIM-1:0]   m_reg2;
    logic [`HDC_DIM-1:0]   m_result;
    int                    m_cnt [`HDC_DIM];
    int                    m_count;
    logic                  m_done;
    logic                  m_run;

    hdc_top dut (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // starts at a falling edge and returns on the one after the access phase
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        err     = pslverr;
        check("pready", 64'd1, 64'(pready));
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        data    = prdata;
        err     = pslverr;
        check("pready", 64'd1, 64'(pready));
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s / %s: expected %h, actual %h", test_name, name, expected, actual);
            fail_count++;
            test_fails++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_fails = 0;
    endtask

    task automatic end_test();
        if (test_fails == 0) begin
            $display("%s: ok", test_name);
        end else begin
            $display("%s: %0d mismatches", test_name, test_fails);
        end
    endtask

    function automatic logic [`HDC_DIM-1:0] rotate_right(input logic [`HDC_DIM-1:0] v);
        return (v >> 1) | (v << (`HDC_DIM - 1));
    endfunction

    function automatic logic [`HDC_DIM-1:0] rotate_left(input logic [`HDC_DIM-1:0] v);
        return (v << 1) | (v >> (`HDC_DIM - 1));
    endfunction

    // majority of the model counters where a tie gives zero
    function automatic logic [`HDC_DIM-1:0] model_sign();
        logic [`HDC_DIM-1:0] s;
        s = '0;
        for (int i = 0; i < `HDC_DIM; i++) begin
            s[i] = (2 * m_cnt[i]) > m_count;
        end
        return s;
    endfunction

    function automatic void clear_bundle();
        m_count = 0;
        m_done  = 1'b0;
        for (int i = 0; i < `HDC_DIM; i++) begin
            m_cnt[i] = 0;
        end
    endfunction

    function automatic void model_exec(input hdc_isa_pkg::opcode_e op,
                                       input logic [`HDC_ADDR_W-1:0] addr);
        if (m_run) begin
            case (op)
                hdc_isa_pkg::LOAD:    m_reg2 = m_mem[addr];
                hdc_isa_pkg::LRSHIFT: m_reg2 = rotate_right(m_mem[addr]);
                hdc_isa_pkg::LLSHIFT: m_reg2 = rotate_left(m_mem[addr]);
                hdc_isa_pkg::LXOR:    m_reg2 = m_reg2 ^ m_mem[addr];
                hdc_isa_pkg::RSHIFT:  m_reg2 = rotate_right(m_reg2);
                hdc_isa_pkg::LSHIFT:  m_reg2 = rotate_left(m_reg2);
                hdc_isa_pkg::XOR:     m_reg2 = m_reg2 ^ m_reg1;
                hdc_isa_pkg::MOVE:    m_reg1 = m_reg2;
                hdc_isa_pkg::SIGN:    m_reg2 = model_sign();
                hdc_isa_pkg::WBITEM:  m_mem[addr] = m_reg2;
                hdc_isa_pkg::LAST:    m_done = 1'b1;
                hdc_isa_pkg::STORE: begin
                    m_result = m_reg2;
                    // stores after last leave the bundle alone
                    if (!m_done) begin
                        if (m_count < CNT_MAX) m_count++;
                        for (int i = 0; i < `HDC_DIM; i++) begin
                            if (m_reg2[i] && m_cnt[i] < CNT_MAX) m_cnt[i]++;
                        end
                    end
                end
                default: ;
            endcase
        end
    endfunction

    task automatic set_ctrl(input logic [31:0] value);
        apb_write(hdc_bus_pkg::CTRL, value, bus_err);
        check("ctrl pslverr", 64'd0, 64'(bus_err));
        m_run = value[hdc_bus_pkg::CTRL_RUN_BIT];
        if (!m_run) begin
            m_reg1 = '0;
            m_reg2 = '0;
        end
        if (value[hdc_bus_pkg::CTRL_CLEAR_BIT]) clear_bundle();
    endtask

    task automatic load_item(input logic [`HDC_ADDR_W-1:0] addr,
                             input logic [`HDC_DIM-1:0] data);
        apb_write(hdc_bus_pkg::ITEM_LO, data[31:0], bus_err);
        check("item_lo pslverr", 64'd0, 64'(bus_err));
        apb_write(hdc_bus_pkg::ITEM_HI, data[63:32], bus_err);
        check("item_hi pslverr", 64'd0, 64'(bus_err));
        apb_write(hdc_bus_pkg::ITEM_ADDR, 32'(addr), bus_err);
        check("item_addr pslverr", 64'd0, 64'(bus_err));
        m_mem[addr] = data;
    endtask

    task automatic issue(input hdc_isa_pkg::opcode_e op, input logic [`HDC_ADDR_W-1:0] addr);
        hdc_isa_pkg::instr_t word;
        word.opcode = op;
        word.rsvd   = '0;
        word.addr   = addr;
        apb_write(hdc_bus_pkg::INSTR, {16'h0000, word}, bus_err);
        check("instr pslverr", 64'd0, 64'(bus_err));
        model_exec(op, addr);
        repeat (3) @(negedge clk);
    endtask

    task automatic read_vec(input logic [7:0] lo, input logic [7:0] hi,
                            output logic [`HDC_DIM-1:0] v);
        logic [31:0] lo_data;
        logic [31:0] hi_data;
        apb_read(lo, lo_data, bus_err);
        check("low half pslverr", 64'd0, 64'(bus_err));
        apb_read(hi, hi_data, bus_err);
        check("high half pslverr", 64'd0, 64'(bus_err));
        v = {hi_data, lo_data};
    endtask

    task automatic store_and_check(input string name);
        logic [`HDC_DIM-1:0] v;
        issue(hdc_isa_pkg::STORE, '0);
        read_vec(hdc_bus_pkg::RESULT_LO, hdc_bus_pkg::RESULT_HI, v);
        check(name, m_result, v);
    endtask

    task automatic read_status(output logic [31:0] data);
        apb_read(hdc_bus_pkg::STATUS, data, bus_err);
        check("status read pslverr", 64'd0, 64'(bus_err));
    endtask

    task automatic test_register_access();
        logic [31:0] data;
        logic        err;
        start_test("register access");
        apb_read(hdc_bus_pkg::STATUS, data, err);
        check("status after reset", 64'd0, 64'(data));
        check("status pslverr", 64'd0, 64'(err));
        apb_read(8'h3C, data, err);
        check("read 0x3C pslverr", 64'd1, 64'(err));
        apb_write(8'h3C, 32'h1234_5678, err);
        check("write 0x3C pslverr", 64'd1, 64'(err));
        set_ctrl(32'h1);
        apb_read(hdc_bus_pkg::CTRL, data, err);
        check("ctrl run set", 64'd1, 64'(data));
        set_ctrl(32'h0);
        apb_read(hdc_bus_pkg::CTRL, data, err);
        check("ctrl run cleared", 64'd0, 64'(data));
        end_test();
    endtask

    task automatic test_load_store();
        logic [`HDC_DIM-1:0] v;
        logic [`HDC_DIM-1:0] item;
        start_test("load and store");
        set_ctrl(32'h1);
        for (int a = 0; a < 8; a++) begin
            item = {$random(seed), $random(seed)};
            load_item(6'(a), item);
        end
        issue(hdc_isa_pkg::LOAD, 6'd3);
        issue(hdc_isa_pkg::STORE, '0);
        read_vec(hdc_bus_pkg::RESULT_LO, hdc_bus_pkg::RESULT_HI, v);
        check("item 3", m_mem[3], v);
        issue(hdc_isa_pkg::LOAD, 6'd7);
        issue(hdc_isa_pkg::STORE, '0);
        read_vec(hdc_bus_pkg::RESULT_LO, hdc_bus_pkg::RESULT_HI, v);
        check("item 7", m_mem[7], v);
        // with run low both instructions are dropped
        set_ctrl(32'h0);
        item = {$random(seed), $random(seed)};
        load_item(6'd9, item);
        issue(hdc_isa_pkg::LOAD, 6'd9);
        issue(hdc_isa_pkg::STORE, '0);
        read_vec(hdc_bus_pkg::RESULT_LO, hdc_bus_pkg::RESULT_HI, v);
        check("result held while stopped", m_result, v);
        set_ctrl(32'h1);
        end_test();
    endtask

    task automatic test_permute_bind();
        start_test("permute and bind");
        issue(hdc_isa_pkg::LRSHIFT, 6'd0);
        store_and_check("lrshift");
        issue(hdc_isa_pkg::LLSHIFT, 6'd1);
        store_and_check("llshift");
        issue(hdc_isa_pkg::LOAD, 6'd2);
        issue(hdc_isa_pkg::RSHIFT, '0);
        store_and_check("rshift");
        issue(hdc_isa_pkg::LSHIFT, '0);
        issue(hdc_isa_pkg::LSHIFT, '0);
        store_and_check("lshift twice");
        issue(hdc_isa_pkg::MOVE, '0);
        issue(hdc_isa_pkg::LOAD, 6'd3);
        issue(hdc_isa_pkg::XOR, '0);
        store_and_check("move then xor");
        issue(hdc_isa_pkg::LXOR, 6'd4);
        store_and_check("lxor");
        end_test();
    endtask

    task automatic test_write_back();
        logic [`HDC_DIM-1:0] v;
        logic [`HDC_DIM-1:0] saved;
        start_test("write-back");
        issue(hdc_isa_pkg::LOAD, 6'd5);
        issue(hdc_isa_pkg::LXOR, 6'd6);
        saved = m_reg2;
        issue(hdc_isa_pkg::WBITEM, 6'd40);
        issue(hdc_isa_pkg::LOAD, 6'd0);
        issue(hdc_isa_pkg::LOAD, 6'd40);
        issue(hdc_isa_pkg::STORE, '0);
        read_vec(hdc_bus_pkg::RESULT_LO, hdc_bus_pkg::RESULT_HI, v);
        check("item 40 after wbitem", saved, v);
        end_test();
    endtask

    task automatic test_bundling();
        logic [`HDC_DIM-1:0] a;
        logic [`HDC_DIM-1:0] b;
        logic [`HDC_DIM-1:0] c;
        logic [`HDC_DIM-1:0] majority;
        logic [`HDC_DIM-1:0] v;
        logic [31:0]         status;
        start_test("bundling");
        a = 64'hFFFF_0000_FF00_F0F0;
        b = 64'h0F0F_FFFF_00FF_CCCC;
        c = 64'h3333_00FF_F0F0_AAAA;
        majority = (a & b) | (a & c) | (b & c);
        set_ctrl(32'h3);
        load_item(6'd50, a);
        load_item(6'd51, b);
        load_item(6'd52, c);
        for (int i = 50; i < 53; i++) begin
            issue(hdc_isa_pkg::LOAD, 6'(i));
            issue(hdc_isa_pkg::STORE, '0);
        end
        issue(hdc_isa_pkg::LAST, '0);
        read_status(status);
        check("done", 64'd1, 64'(status[hdc_bus_pkg::STATUS_DONE_BIT]));
        check("count", 64'd3,
              64'(status[hdc_bus_pkg::STATUS_COUNT_MSB:hdc_bus_pkg::STATUS_COUNT_LSB]));
        read_vec(hdc_bus_pkg::SIGN_LO, hdc_bus_pkg::SIGN_HI, v);
        check("sign majority", majority, v);
        check("sign model", model_sign(), v);
        // bundle is frozen now
        issue(hdc_isa_pkg::STORE, '0);
        read_status(status);
        check("count after frozen store", 64'(m_count),
              64'(status[hdc_bus_pkg::STATUS_COUNT_MSB:hdc_bus_pkg::STATUS_COUNT_LSB]));
        issue(hdc_isa_pkg::SIGN, '0);
        issue(hdc_isa_pkg::STORE, '0);
        read_vec(hdc_bus_pkg::RESULT_LO, hdc_bus_pkg::RESULT_HI, v);
        check("sign through store", majority, v);
        set_ctrl(32'h3);
        read_status(status);
        check("status after clear", 64'd0, 64'(status));
        end_test();
    endtask

    initial begin
        seed       = 91881;
        pass_count = 0;
        fail_count = 0;
        test_fails = 0;
        reset      = 1'b1;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        m_run      = 1'b0;
        m_reg1     = '0;
        m_reg2     = '0;
        m_result   = '0;
        clear_bundle();
        for (int i = 0; i < `HDC_ITEMS; i++) begin
            m_mem[i] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        test_register_access();
        test_load_store();
        test_permute_bind();
        test_write_back();
        test_bundling();
        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* rtl/hdc_top.sv */
`timescale 1ns/1ps
`include "hdc_cfg.svh"

module hdc_top (
    input  logic          clk,
    input  logic          reset,
    input  logic [7:0]    paddr,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  logic [31:0]   pwdata,
    output logic [31:0]   prdata,
    output logic          pready,
    output logic          pslverr
);

    logic [`HDC_CNT_W-1:0]    bundle_count;

    hdc_ctrl_if ctrl_bus ();
    hdc_vec_if  vec_bus ();

    // APB slave and instruction issue
    hdc_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .count   (bundle_count),
        .ctrl    (ctrl_bus.regs),
        .vec     (vec_bus.regs)
    );

    hdc_core u_core (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.core),
        .vec   (vec_bus.core)
    );

    hdc_bundler u_bundler (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl_bus.bundler),
        .vec   (vec_bus.bundler),
        .count (bundle_count)
    );

endmodule

/* rtl/hdc_bundler.sv */
`timescale 1ns/1ps
`include "hdc_cfg.svh"

module hdc_bundler (
    input  logic                     clk,
    input  logic                     reset,
    hdc_ctrl_if.bundler              ctrl,
    hdc_vec_if.bundler               vec,
    output logic [`HDC_CNT_W-1:0]    count
);

    logic [`HDC_CNT_W-1:0]    bit_cnt [`HDC_DIM];
    logic [`HDC_CNT_W-1:0]    store_cnt;
    logic                     done_q;
    logic                     take;

    // frozen once last has been seen
    assign take = vec.store_valid & ~done_q;

    always_ff @(posedge clk) begin
        if (reset || ctrl.clear) begin
            store_cnt <= '0;
            done_q    <= 1'b0;
            for (int i = 0; i < `HDC_DIM; i++) begin
                bit_cnt[i] <= '0;
            end
        end else if (vec.last) begin
            done_q <= 1'b1;
        end else if (take) begin
            if (store_cnt != '1) begin
                store_cnt <= store_cnt + 1'b1;
            end
            for (int i = 0; i < `HDC_DIM; i++) begin
                // saturate instead of wrapping
                if (vec.store_vec[i] && bit_cnt[i] != '1) begin
                    bit_cnt[i] <= bit_cnt[i] + 1'b1;
                end
            end
        end
    end

    // majority vote, a tie gives zero
    always_comb begin
        for (int i = 0; i < `HDC_DIM; i++) begin
            vec.sign_vec[i] = {bit_cnt[i], 1'b0} > {1'b0, store_cnt};
        end
    end

    assign vec.done = done_q;
    assign count    = store_cnt;

endmodule

/* rtl/hdc_core.sv */
`timescale 1ns/1ps
`include "hdc_cfg.svh"

module hdc_core (
    input  logic         clk,
    input  logic         reset,
    hdc_ctrl_if.core     ctrl,
    hdc_vec_if.core      vec
);

    logic [`HDC_DIM-1:0]       item_mem [`HDC_ITEMS];

    // reg_0 fetched item, reg_1 held operand, reg_2 accumulator
    logic [`HDC_DIM-1:0]       reg_0;
    logic [`HDC_DIM-1:0]       reg_1;
    logic [`HDC_DIM-1:0]       reg_2;

    logic                      issue;
    logic                      fetch_item;
    logic                      s1_valid;
    hdc_isa_pkg::opcode_e      s1_op;
    logic [`HDC_ADDR_W-1:0]    wb_addr;
    logic                      wb_en;
    logic                      store_q;
    logic                      last_q;

    // instructions are dropped while run is low
    assign issue = ctrl.instr_valid & ctrl.run;

    always_comb begin
        case (ctrl.instr.opcode)
            hdc_isa_pkg::LOAD,
            hdc_isa_pkg::LRSHIFT,
            hdc_isa_pkg::LLSHIFT,
            hdc_isa_pkg::LXOR: fetch_item = 1'b1;
            default:           fetch_item = 1'b0;
        endcase
    end

    assign wb_en = s1_valid & ctrl.run & (s1_op == hdc_isa_pkg::WBITEM);

    // item memory, write-back wins over a host write
    always_ff @(posedge clk) begin
        if (wb_en) begin
            item_mem[wb_addr] <= reg_2;
        end else if (ctrl.item_we) begin
            item_mem[ctrl.item_addr] <= ctrl.item_data;
        end
        if (issue && fetch_item) begin
            reg_0 <= item_mem[ctrl.instr.addr];
        end
        if (issue && ctrl.instr.opcode == hdc_isa_pkg::WBITEM) begin
            wb_addr <= ctrl.instr.addr;
        end
    end

    // stage 1 latch
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_op    <= hdc_isa_pkg::NOP;
        end else begin
            s1_valid <= issue;
            if (issue) begin
                s1_op <= ctrl.instr.opcode;
            end
        end
    end

    // stage 2 execute
    always_ff @(posedge clk) begin
        if (reset || !ctrl.run) begin
            reg_1   <= '0;
            reg_2   <= '0;
            store_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            store_q <= 1'b0;
            last_q  <= 1'b0;
            if (s1_valid) begin
                case (s1_op)
                    hdc_isa_pkg::LOAD:    reg_2 <= reg_0;
                    // right rotate, bit 0 wraps to the top
                    hdc_isa_pkg::LRSHIFT: reg_2 <= {reg_0[0], reg_0[`HDC_DIM-1:1]};
                    hdc_isa_pkg::LLSHIFT: reg_2 <= {reg_0[`HDC_DIM-2:0], reg_0[`HDC_DIM-1]};
                    hdc_isa_pkg::LXOR:    reg_2 <= reg_2 ^ reg_0;
                    hdc_isa_pkg::RSHIFT:  reg_2 <= {reg_2[0], reg_2[`HDC_DIM-1:1]};
                    hdc_isa_pkg::LSHIFT:  reg_2 <= {reg_2[`HDC_DIM-2:0], reg_2[`HDC_DIM-1]};
                    hdc_isa_pkg::XOR:     reg_2 <= reg_2 ^ reg_1;
                    hdc_isa_pkg::MOVE:    reg_1 <= reg_2;
                    hdc_isa_pkg::SIGN:    reg_2 <= vec.sign_vec;
                    hdc_isa_pkg::STORE:   store_q <= 1'b1;
                    hdc_isa_pkg::LAST:    last_q <= 1'b1;
                    // WBITEM is handled by the memory write port
                    default: ;
                endcase
            end
        end
    end

    // reg_2 cannot change while store_valid is up
    assign vec.store_valid = store_q;
    assign vec.store_vec   = reg_2;
    assign vec.last        = last_q;

endmodule

/* rtl/hdc_regs.sv */
`timescale 1ns/1ps
`include "hdc_cfg.svh"

module hdc_regs (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [7:0]               paddr,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  logic [31:0]              pwdata,
    output logic [31:0]              prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  logic [`HDC_CNT_W-1:0]    count,
    hdc_ctrl_if.regs                 ctrl,
    hdc_vec_if.regs                  vec
);

    logic                        access;
    logic                        addr_ok;
    logic                        wr_en;

    logic                        run_q;
    logic                        clear_q;
    logic                        instr_valid_q;
    logic                        item_we_q;
    hdc_isa_pkg::instr_t         instr_q;
    logic [`HDC_ADDR_W-1:0]      item_addr_q;
    logic [31:0]                 item_lo_q;
    logic [31:0]                 item_hi_q;
    logic [`HDC_DIM-1:0]         result_q;
    logic [31:0]                 status;

    // no wait states
    assign pready = 1'b1;

    assign access  = psel & penable;
    assign wr_en   = access & pwrite & addr_ok;
    assign pslverr = access & ~addr_ok;

    always_comb begin
        status = '0;
        status[hdc_bus_pkg::STATUS_DONE_BIT] = vec.done;
        status[hdc_bus_pkg::STATUS_COUNT_MSB:hdc_bus_pkg::STATUS_COUNT_LSB] = count;
    end

    // address decode and read mux
    always_comb begin
        addr_ok = 1'b1;
        prdata  = '0;
        case (paddr)
            hdc_bus_pkg::CTRL:      prdata[hdc_bus_pkg::CTRL_RUN_BIT] = run_q;
            hdc_bus_pkg::STATUS:    prdata = status;
            hdc_bus_pkg::INSTR:     prdata = 32'(instr_q);
            hdc_bus_pkg::ITEM_ADDR: prdata = 32'(item_addr_q);
            hdc_bus_pkg::ITEM_LO:   prdata = item_lo_q;
            hdc_bus_pkg::ITEM_HI:   prdata = item_hi_q;
            hdc_bus_pkg::RESULT_LO: prdata = result_q[31:0];
            hdc_bus_pkg::RESULT_HI: prdata = result_q[`HDC_DIM-1:32];
            hdc_bus_pkg::SIGN_LO:   prdata = vec.sign_vec[31:0];
            hdc_bus_pkg::SIGN_HI:   prdata = vec.sign_vec[`HDC_DIM-1:32];
            default:                addr_ok = 1'b0;
        endcase
    end

    // control bits and one-cycle strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            run_q         <= 1'b0;
            clear_q       <= 1'b0;
            instr_valid_q <= 1'b0;
            item_we_q     <= 1'b0;
            instr_q       <= '0;
            result_q      <= '0;
        end else begin
            clear_q       <= 1'b0;
            instr_valid_q <= 1'b0;
            item_we_q     <= 1'b0;
            if (vec.store_valid) begin
                result_q <= vec.store_vec;
            end
            if (wr_en) begin
                case (paddr)
                    hdc_bus_pkg::CTRL: begin
                        run_q   <= pwdata[hdc_bus_pkg::CTRL_RUN_BIT];
                        clear_q <= pwdata[hdc_bus_pkg::CTRL_CLEAR_BIT];
                    end
                    hdc_bus_pkg::INSTR: begin
                        instr_q       <= hdc_isa_pkg::instr_t'(pwdata[15:0]);
                        instr_valid_q <= 1'b1;
                    end
                    hdc_bus_pkg::ITEM_ADDR: begin
                        item_we_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    // item staging
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (paddr)
                hdc_bus_pkg::ITEM_ADDR: item_addr_q <= pwdata[`HDC_ADDR_W-1:0];
                hdc_bus_pkg::ITEM_LO:   item_lo_q   <= pwdata;
                hdc_bus_pkg::ITEM_HI:   item_hi_q   <= pwdata;
                default: ;
            endcase
        end
    end

    assign ctrl.run         = run_q;
    assign ctrl.clear       = clear_q;
    assign ctrl.instr_valid = instr_valid_q;
    assign ctrl.instr       = instr_q;
    assign ctrl.item_we     = item_we_q;
    assign ctrl.item_addr   = item_addr_q;
    assign ctrl.item_data   = {item_hi_q, item_lo_q};

endmodule

/* rtl/hdc_exec_if.sv */
`timescale 1ns/1ps
`include "hdc_cfg.svh"

// control path from the register block
interface hdc_ctrl_if;
    logic                         run;
    logic                         instr_valid;
    hdc_isa_pkg::instr_t          instr;
    logic                         item_we;
    logic [`HDC_ADDR_W-1:0]       item_addr;
    logic [`HDC_DIM-1:0]          item_data;
    logic                         clear;

    modport regs (output run, instr_valid, instr, item_we, item_addr, item_data, clear);
    modport core (input run, instr_valid, instr, item_we, item_addr, item_data);
    modport bundler (input clear);
endinterface

// vector results between core, bundler and register block
interface hdc_vec_if;
    logic                         store_valid;
    logic [`HDC_DIM-1:0]          store_vec;
    logic                         last;
    logic [`HDC_DIM-1:0]          sign_vec;
    logic                         done;

    modport core (output store_valid, store_vec, last, input sign_vec);
    modport bundler (input store_valid, store_vec, last, output sign_vec, done);
    modport regs (input store_valid, store_vec, sign_vec, done);
endinterface

/* rtl/hdc_bus_pkg.sv */
package hdc_bus_pkg;

    // APB byte offsets
    typedef enum logic [7:0] {
        CTRL      = 8'h00,
        STATUS    = 8'h04,
        INSTR     = 8'h08,
        ITEM_ADDR = 8'h0C,
        ITEM_LO   = 8'h10,
        ITEM_HI   = 8'h14,
        RESULT_LO = 8'h18,
        RESULT_HI = 8'h1C,
        SIGN_LO   = 8'h20,
        SIGN_HI   = 8'h24
    } reg_addr_e;

    // CTRL fields
    parameter int CTRL_RUN_BIT   = 0;
    parameter int CTRL_CLEAR_BIT = 1;

    // STATUS fields
    parameter int STATUS_DONE_BIT  = 0;
    parameter int STATUS_COUNT_LSB = 8;
    parameter int STATUS_COUNT_MSB = 15;

endpackage

/* rtl/hdc_isa_pkg.sv */
`include "hdc_cfg.svh"

package hdc_isa_pkg;

    // core opcodes, top nibble of every instruction
    typedef enum logic [3:0] {
        NOP     = 4'd0,
        LOAD    = 4'd1,
        LRSHIFT = 4'd2,
        LLSHIFT = 4'd3,
        LXOR    = 4'd4,
        RSHIFT  = 4'd5,
        LSHIFT  = 4'd6,
        XOR     = 4'd7,
        STORE   = 4'd8,
        LAST    = 4'd9,
        MOVE    = 4'd10,
        SIGN    = 4'd11,
        WBITEM  = 4'd12
    } opcode_e;

    // 16-bit instruction word
    typedef struct packed {
        opcode_e                      opcode;
        logic [11-`HDC_ADDR_W:0]      rsvd;
        logic [`HDC_ADDR_W-1:0]       addr;
    } instr_t;

endpackage

/* rtl/hdc_cfg.svh */
`ifndef HDC_CFG_SVH
`define HDC_CFG_SVH

// hypervector width in bits
`define HDC_DIM 64

// item memory depth and matching address width
`define HDC_ITEMS 64
`define HDC_ADDR_W 6

// bundle counter width, also used for the store count
`define HDC_CNT_W 8

`endif
